// File: hw/ifu_pkg.sv
package ifu_pkg;

    // fetch datapath widths
    localparam int INST_ADDR_W = 32;    // fetch address
    localparam int INST_DATA_W = 32;    // one instruction word
    localparam int AXI_ID_W    = 2;     // ARID / RID
    localparam int AXI_RESP_W  = 2;     // RRESP

    // queue sizes
    localparam int ADDR_Q_DEPTH   = 4;  // outstanding reads
    localparam int INST_BUF_DEPTH = 4;  // words held under stall

    // pointer widths derived from the depths
    localparam int ADDR_Q_PTR_W   = $clog2(ADDR_Q_DEPTH);
    localparam int INST_BUF_PTR_W = $clog2(INST_BUF_DEPTH);

    // program counter
    localparam logic [INST_ADDR_W-1:0] RESET_PC = 32'h8000_0000;  // boot address
    localparam logic [INST_ADDR_W-1:0] PC_STEP  = 32'd4;          // one word per fetch

    // rresp[1] set means SLVERR or DECERR
    localparam int RRESP_ERR_BIT = 1;

    // queue operation, encoded as {push, pop}
    typedef enum logic [1:0] {
        FIFO_NOP      = 2'b00,
        FIFO_POP      = 2'b01,
        FIFO_PUSH     = 2'b10,
        FIFO_PUSH_POP = 2'b11
    } fifo_op_e;

endpackage

// File: hw/ifu_pc_gen.sv
`timescale 1ns/1ps

module ifu_pc_gen
    import ifu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   jump_i,         // one-cycle redirect strobe
    input  logic [INST_ADDR_W-1:0] jump_target_i,  // new fetch address
    input  logic                   ar_fire_i,      // read address accepted this cycle
    output logic [INST_ADDR_W-1:0] pc_o
);

    logic [INST_ADDR_W-1:0] pc_q;
    logic [INST_ADDR_W-1:0] pc_next;

    // next fetch address
    // jump wins over a sequential step
    always_comb begin
        pc_next = pc_q;
        if (jump_i) begin
            pc_next = jump_target_i;
        end else if (ar_fire_i) begin
            pc_next = pc_q + PC_STEP;  // next sequential word
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;  // boot vector
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;  // also the live araddr

endmodule

// File: hw/ifu_addr_queue.sv
`timescale 1ns/1ps

module ifu_addr_queue
    import ifu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,      // drop everything outstanding
    input  logic                   push_i,       // ar handshake
    input  logic [INST_ADDR_W-1:0] push_addr_i,
    input  logic                   pop_i,        // response consumed
    output logic [INST_ADDR_W-1:0] head_addr_o,  // oldest outstanding address
    output logic                   empty_o,
    output logic                   full_o
);

    logic [INST_ADDR_W-1:0]  mem [ADDR_Q_DEPTH];  // address storage
    logic [ADDR_Q_PTR_W-1:0] rd_ptr;
    logic [ADDR_Q_PTR_W-1:0] wr_ptr;
    logic [ADDR_Q_PTR_W:0]   count;               // one extra bit for full
    logic                    do_push;
    logic                    do_pop;
    fifo_op_e                op;

    assign empty_o = (count == '0);
    assign full_o  = (count == (ADDR_Q_PTR_W+1)'(ADDR_Q_DEPTH));

    // guard strobes against overflow and underflow
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign op      = fifo_op_e'({do_push, do_pop});

    // pointers and count
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            case (op)
                FIFO_PUSH: begin
                    wr_ptr <= (wr_ptr == ADDR_Q_PTR_W'(ADDR_Q_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
                    count  <= count + 1'b1;
                end
                FIFO_POP: begin
                    rd_ptr <= (rd_ptr == ADDR_Q_PTR_W'(ADDR_Q_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
                    count  <= count - 1'b1;
                end
                FIFO_PUSH_POP: begin  // count unchanged
                    wr_ptr <= (wr_ptr == ADDR_Q_PTR_W'(ADDR_Q_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
                    rd_ptr <= (rd_ptr == ADDR_Q_PTR_W'(ADDR_Q_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
                end
                default: ;            // FIFO_NOP, hold
            endcase
        end
    end

    // storage write, payload only
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_addr_i;
        end
    end

    assign head_addr_o = mem[rd_ptr];  // combinational head

endmodule

// File: hw/ifu_inst_buffer.sv
`timescale 1ns/1ps

module ifu_inst_buffer
    import ifu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,     // jump, drop buffered words
    input  logic [AXI_ID_W-1:0]    cur_id_i,    // id of the live fetch stream
    input  logic                   stall_i,     // decoder cannot take a word
    input  logic [AXI_ID_W-1:0]    r_id_i,
    input  logic [INST_DATA_W-1:0] r_data_i,
    input  logic [AXI_RESP_W-1:0]  r_resp_i,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    output logic                   beat_o,      // good beat of current stream
    output logic                   error_o,     // error seen, held until reset
    output logic                   pop_o,       // head handed to the decoder
    output logic                   empty_o,
    output logic [INST_DATA_W-1:0] data_o       // buffer head
);

    logic [INST_DATA_W-1:0]    mem [INST_BUF_DEPTH];
    logic [INST_BUF_PTR_W-1:0] rd_ptr;
    logic [INST_BUF_PTR_W-1:0] wr_ptr;
    logic [INST_BUF_PTR_W:0]   count;
    logic                      full;
    logic                      r_fire;    // r handshake
    logic                      id_match;  // beat belongs to current stream
    logic                      err_beat;
    logic                      err_q;     // sticky error
    logic                      push;
    fifo_op_e                  op;

    assign empty_o = (count == '0);
    assign full    = (count == (INST_BUF_PTR_W+1)'(INST_BUF_DEPTH));

    // stale ids still get ready, they are just ignored
    assign r_ready_o = !full;
    assign r_fire    = r_valid_i && r_ready_o;
    assign id_match  = (r_id_i == cur_id_i);

    // beat classification
    assign beat_o   = r_fire && id_match && !r_resp_i[RRESP_ERR_BIT];
    assign err_beat = r_fire && id_match && r_resp_i[RRESP_ERR_BIT];

    // park the beat under stall, or behind older words to keep order
    assign push  = beat_o && (stall_i || !empty_o);
    assign pop_o = !stall_i && !empty_o;  // oldest word goes out first
    assign op    = fifo_op_e'({push, pop_o});

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            case (op)
                FIFO_PUSH: begin
                    wr_ptr <= (wr_ptr == INST_BUF_PTR_W'(INST_BUF_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
                    count  <= count + 1'b1;
                end
                FIFO_POP: begin
                    rd_ptr <= (rd_ptr == INST_BUF_PTR_W'(INST_BUF_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
                    count  <= count - 1'b1;
                end
                FIFO_PUSH_POP: begin
                    wr_ptr <= (wr_ptr == INST_BUF_PTR_W'(INST_BUF_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
                    rd_ptr <= (rd_ptr == INST_BUF_PTR_W'(INST_BUF_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
                end
                default: ;
            endcase
        end
    end

    // word storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= r_data_i;
        end
    end

    // error flag, only reset clears it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_q <= 1'b0;
        end else if (err_beat) begin
            err_q <= 1'b1;
        end
    end

    assign error_o = err_q || err_beat;  // visible in the beat cycle already
    assign data_o  = mem[rd_ptr];

endmodule

// File: hw/ifu_fetch_ctrl.sv
`timescale 1ns/1ps

module ifu_fetch_ctrl
    import ifu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall_i,
    input  logic                   jump_i,
    input  logic                   ar_ready_i,
    input  logic [INST_ADDR_W-1:0] pc_i,            // current fetch address
    input  logic [INST_ADDR_W-1:0] aq_head_addr_i,
    input  logic                   aq_empty_i,
    input  logic                   aq_full_i,
    input  logic                   ib_beat_i,
    input  logic                   ib_error_i,
    input  logic                   ib_pop_i,
    input  logic                   ib_empty_i,
    input  logic [INST_DATA_W-1:0] ib_data_i,
    input  logic [INST_DATA_W-1:0] r_data_i,        // live beat data
    output logic [AXI_ID_W-1:0]    ar_id_o,
    output logic                   ar_valid_o,
    output logic                   ar_fire_o,
    output logic                   aq_push_o,
    output logic                   aq_pop_o,
    output logic                   flush_o,
    output logic [INST_DATA_W-1:0] inst_data_o,
    output logic [INST_ADDR_W-1:0] inst_addr_o,
    output logic                   inst_valid_o,
    output logic                   pc_stall_o
);

    logic [AXI_ID_W-1:0] id_q;        // stream id, bumped per jump
    logic                err_seen_q;  // error flag one cycle late
    logic                err_pop;     // first error beat retires its address
    logic                live_deliver;
    logic                consume;     // one response leaves the address stream
    logic                same_cycle;  // response meets its own ar handshake

    // issue only when nothing waits in the buffer
    assign ar_valid_o = !stall_i && !jump_i && !aq_full_i && ib_empty_i;
    assign ar_fire_o  = ar_valid_o && ar_ready_i;
    assign ar_id_o    = id_q;
    assign flush_o    = jump_i;  // clears both queues

    // bypass the buffer when it is empty and the decoder is free
    assign live_deliver = ib_beat_i && ib_empty_i && !stall_i;
    assign inst_valid_o = (ib_pop_i || live_deliver) && !jump_i;  // nothing in jump cycle

    // error beat consumes an address without a delivery
    // rising edge of the held flag, so it fires in the beat cycle
    assign err_pop = ib_error_i && !err_seen_q;
    assign consume = inst_valid_o || err_pop;

    // queue empty and response now, so it answers the address just issued
    assign same_cycle = ar_fire_o && aq_empty_i && consume;
    assign aq_push_o  = ar_fire_o && !same_cycle;
    assign aq_pop_o   = consume && !aq_empty_i;

    // pair word with address
    assign inst_data_o = ib_empty_i ? r_data_i : ib_data_i;
    assign inst_addr_o = aq_empty_i ? pc_i : aq_head_addr_i;  // pc when bypassing

    // hold the pc while ar waits, queue full or words parked
    assign pc_stall_o = (ar_valid_o && !ar_ready_i) || aq_full_i || !ib_empty_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_q       <= '0;
            err_seen_q <= 1'b0;
        end else begin
            err_seen_q <= ib_error_i;
            if (jump_i) begin
                id_q <= id_q + 1'b1;  // old responses no longer match
            end
        end
    end

endmodule

// File: hw/ifu_top.sv
`timescale 1ns/1ps

module ifu_top
    import ifu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // axi read address
    output logic [AXI_ID_W-1:0]    ar_id_o,
    output logic [INST_ADDR_W-1:0] ar_addr_o,
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    // axi read data
    input  logic [AXI_ID_W-1:0]    r_id_i,
    input  logic [INST_DATA_W-1:0] r_data_i,
    input  logic [AXI_RESP_W-1:0]  r_resp_i,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    // core side
    input  logic                   stall_i,
    input  logic                   jump_i,
    input  logic [INST_ADDR_W-1:0] jump_target_i,
    output logic [INST_DATA_W-1:0] inst_data_o,
    output logic [INST_ADDR_W-1:0] inst_addr_o,
    output logic                   inst_valid_o,
    output logic                   pc_stall_o,
    output logic                   read_resp_error_o
);

    logic                   ar_fire;
    logic [INST_ADDR_W-1:0] pc;
    logic                   aq_push;
    logic                   aq_pop;
    logic                   flush;         // shared by both queues
    logic [INST_ADDR_W-1:0] aq_head_addr;
    logic                   aq_empty;
    logic                   aq_full;
    logic                   ib_beat;
    logic                   ib_pop;
    logic                   ib_empty;
    logic [INST_DATA_W-1:0] ib_data;

    assign ar_addr_o = pc;  // araddr is the pc itself

    ifu_pc_gen u_pc_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .jump_i        (jump_i),
        .jump_target_i (jump_target_i),
        .ar_fire_i     (ar_fire),
        .pc_o          (pc)
    );

    ifu_addr_queue u_addr_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush),
        .push_i      (aq_push),
        .push_addr_i (pc),
        .pop_i       (aq_pop),
        .head_addr_o (aq_head_addr),
        .empty_o     (aq_empty),
        .full_o      (aq_full)
    );

    // cur_id comes straight from the arid register
    ifu_inst_buffer u_inst_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush_i   (flush),
        .cur_id_i  (ar_id_o),
        .stall_i   (stall_i),
        .r_id_i    (r_id_i),
        .r_data_i  (r_data_i),
        .r_resp_i  (r_resp_i),
        .r_valid_i (r_valid_i),
        .r_ready_o (r_ready_o),
        .beat_o    (ib_beat),
        .error_o   (read_resp_error_o),
        .pop_o     (ib_pop),
        .empty_o   (ib_empty),
        .data_o    (ib_data)
    );

    ifu_fetch_ctrl u_fetch_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (stall_i),
        .jump_i         (jump_i),
        .ar_ready_i     (ar_ready_i),
        .pc_i           (pc),
        .aq_head_addr_i (aq_head_addr),
        .aq_empty_i     (aq_empty),
        .aq_full_i      (aq_full),
        .ib_beat_i      (ib_beat),
        .ib_error_i     (read_resp_error_o),
        .ib_pop_i       (ib_pop),
        .ib_empty_i     (ib_empty),
        .ib_data_i      (ib_data),
        .r_data_i       (r_data_i),
        .ar_id_o        (ar_id_o),
        .ar_valid_o     (ar_valid_o),
        .ar_fire_o      (ar_fire),
        .aq_push_o      (aq_push),
        .aq_pop_o       (aq_pop),
        .flush_o        (flush),
        .inst_data_o    (inst_data_o),
        .inst_addr_o    (inst_addr_o),
        .inst_valid_o   (inst_valid_o),
        .pc_stall_o     (pc_stall_o)
    );

endmodule

// File: testbench/tb_axi_rom.sv
`timescale 1ns/1ps

module tb_axi_rom
    import ifu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [AXI_ID_W-1:0]    ar_id_i,
    input  logic [INST_ADDR_W-1:0] ar_addr_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    output logic [AXI_ID_W-1:0]    r_id_o,
    output logic [INST_DATA_W-1:0] r_data_o,
    output logic [AXI_RESP_W-1:0]  r_resp_o,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    input  logic                   hold_ar_i,   // force arready low
    input  logic                   err_en_i,
    input  logic [INST_ADDR_W-1:0] err_addr_i   // answered with slverr
);

    localparam logic [INST_DATA_W-1:0] DATA_KEY = 32'h1357_9BDF;  // word = addr ^ key
    localparam int                     RAND_SEED = 32'h5147_b3b8;  // latency draws

    logic [INST_ADDR_W-1:0] pend_addr [$];  // accepted reads, oldest first
    logic [AXI_ID_W-1:0]    pend_id [$];
    int                     pend_due [$];   // cycle when the answer may start
    int                     cyc = 0;
    int                     last_due = 0;   // keeps answers in order
    logic                   r_valid_q = 1'b0;
    logic [AXI_ID_W-1:0]    r_id_q = '0;
    logic [INST_DATA_W-1:0] r_data_q = '0;
    logic [AXI_RESP_W-1:0]  r_resp_q = '0;

    assign ar_ready_o = !hold_ar_i;
    assign r_valid_o  = r_valid_q;
    assign r_id_o     = r_id_q;
    assign r_data_o   = r_data_q;
    assign r_resp_o   = r_resp_q;

    always @(posedge clk) begin
        int lat;
        int due;
        cyc = cyc + 1;
        if (cyc == 1) begin
            void'($urandom(RAND_SEED));  // first edge, before any draw
        end
        if (!rst_n) begin
            pend_addr.delete();
            pend_id.delete();
            pend_due.delete();
            last_due = 0;
        end else begin
            if (r_valid_q && r_ready_i) begin  // beat taken, retire it
                void'(pend_addr.pop_front());
                void'(pend_id.pop_front());
                void'(pend_due.pop_front());
            end
            if (ar_valid_i && ar_ready_o) begin
                lat = 1 + int'($urandom % 3);  // 1 to 3 cycles
                due = cyc + lat;
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pend_addr.push_back(ar_addr_i);
                pend_id.push_back(ar_id_i);
                pend_due.push_back(due);
            end
        end
        #1;
        // present the oldest read once its latency is over
        if (pend_id.size() > 0 && pend_due[0] <= cyc) begin
            r_valid_q = 1'b1;
            r_id_q    = pend_id[0];
            r_data_q  = pend_addr[0] ^ DATA_KEY;
            r_resp_q  = '0;
            r_resp_q[RRESP_ERR_BIT] = err_en_i && (pend_addr[0] == err_addr_i);
        end else begin
            r_valid_q = 1'b0;
        end
    end

endmodule

// File: testbench/tb_ifu_top.sv
`timescale 1ns/1ps

module tb_ifu_top
    import ifu_pkg::*;
();

    localparam logic [INST_DATA_W-1:0] DATA_KEY = 32'h1357_9BDF;
    localparam int CYCLE_LIMIT = 4000;  // whole run
    localparam int WORD_WAIT   = 50;    // per delivered word

    logic                   clk;
    logic                   rst_n;
    logic [AXI_ID_W-1:0]    ar_id;
    logic [INST_ADDR_W-1:0] ar_addr;
    logic                   ar_valid;
    logic                   ar_ready;
    logic [AXI_ID_W-1:0]    r_id;
    logic [INST_DATA_W-1:0] r_data;
    logic [AXI_RESP_W-1:0]  r_resp;
    logic                   r_valid;
    logic                   r_ready;
    logic                   stall_i;
    logic                   jump_i;
    logic [INST_ADDR_W-1:0] jump_target_i;
    logic [INST_DATA_W-1:0] inst_data_o;
    logic [INST_ADDR_W-1:0] inst_addr_o;
    logic                   inst_valid_o;
    logic                   pc_stall_o;
    logic                   read_resp_error_o;
    logic                   hold_ar;
    logic                   err_en;
    logic [INST_ADDR_W-1:0] err_addr;

    int                     errors = 0;
    int                     cycles = 0;
    logic [INST_ADDR_W-1:0] next_addr;        // next expected fetch address
    logic [AXI_ID_W-1:0]    exp_id = '0;      // arid, one step per jump
    logic                   skip_en = 1'b0;   // error address never delivered
    logic [INST_ADDR_W-1:0] skip_addr = '0;
    logic [INST_ADDR_W-1:0] got_addr [$];     // delivered words, in order
    logic [INST_DATA_W-1:0] got_data [$];

    ifu_top ifu_top_inst (
        .clk(clk), .rst_n(rst_n),
        .ar_id_o(ar_id), .ar_addr_o(ar_addr), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
        .r_id_i(r_id), .r_data_i(r_data), .r_resp_i(r_resp), .r_valid_i(r_valid),
        .r_ready_o(r_ready), .stall_i(stall_i), .jump_i(jump_i),
        .jump_target_i(jump_target_i), .inst_data_o(inst_data_o),
        .inst_addr_o(inst_addr_o), .inst_valid_o(inst_valid_o),
        .pc_stall_o(pc_stall_o), .read_resp_error_o(read_resp_error_o)
    );

    tb_axi_rom u_rom (
        .clk(clk), .rst_n(rst_n),
        .ar_id_i(ar_id), .ar_addr_i(ar_addr), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .r_id_o(r_id), .r_data_o(r_data), .r_resp_o(r_resp), .r_valid_o(r_valid),
        .r_ready_i(r_ready), .hold_ar_i(hold_ar), .err_en_i(err_en), .err_addr_i(err_addr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    // record every delivered word
    always @(posedge clk) begin
        if (rst_n && inst_valid_o) begin
            got_addr.push_back(inst_addr_o);
            got_data.push_back(inst_data_o);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_addr(input string name, input logic [INST_ADDR_W-1:0] got,
                              input logic [INST_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input logic [INST_DATA_W-1:0] got,
                              input logic [INST_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input logic [AXI_ID_W-1:0] got,
                            input logic [AXI_ID_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;  // drive point after the edge
    endtask

    // pop n delivered words, each checked against the running sequence
    task automatic take_words(input int n);
        int waited;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            while (got_addr.size() == 0 && waited < WORD_WAIT) begin
                tick();
                waited++;
            end
            if (got_addr.size() == 0) begin
                $display("no instruction delivered for address %h within %0d cycles",
                         next_addr, WORD_WAIT);
                errors++;
                return;
            end
            if (skip_en && next_addr == skip_addr) begin
                next_addr = next_addr + 32'd4;  // error beat is dropped
            end
            check_addr("inst_addr_o", got_addr.pop_front(), next_addr);
            check_data("inst_data_o", got_data.pop_front(), next_addr ^ DATA_KEY);
            next_addr = next_addr + 32'd4;
        end
    endtask

    task automatic do_jump(input logic [INST_ADDR_W-1:0] target);
        tick();
        got_addr.delete();  // anything older is pre-jump
        got_data.delete();
        jump_target_i = target;
        jump_i        = 1'b1;
        tick();
        jump_i    = 1'b0;
        next_addr = target;
        exp_id    = exp_id + 1'b1;  // new stream id
        check_id("ar_id_o", ar_id, exp_id);
    endtask

    task automatic reset_and_fetch_test();
        repeat (3) @(posedge clk);  // reset held 3 cycles
        #1;
        rst_n = 1'b1;
        check_flag("ar_valid_o", ar_valid, 1'b0);
        check_flag("inst_valid_o", inst_valid_o, 1'b0);
        check_flag("read_resp_error_o", read_resp_error_o, 1'b0);
        check_flag("r_ready_o", r_ready, 1'b1);
        check_flag("pc_stall_o", pc_stall_o, 1'b0);
        check_addr("ar_addr_o", ar_addr, RESET_PC);
        check_id("ar_id_o", ar_id, exp_id);
        tick();
        stall_i = 1'b0;
        take_words(8);
    endtask

    task automatic stall_test();
        tick();
        stall_i = 1'b1;
        repeat (8) begin
            tick();
            check_flag("inst_valid_o", inst_valid_o, 1'b0);  // nothing under stall
        end
        stall_i = 1'b0;
        take_words(8);
    endtask

    task automatic jump_test();
        take_words(2);
        do_jump(32'h8000_1000);  // old reads still in flight
        take_words(6);
    endtask

    task automatic error_test();
        check_flag("read_resp_error_o", read_resp_error_o, 1'b0);
        err_addr  = 32'h8000_2008;
        err_en    = 1'b1;
        skip_addr = 32'h8000_2008;
        skip_en   = 1'b1;
        do_jump(32'h8000_2000);
        take_words(5);
        check_flag("read_resp_error_o", read_resp_error_o, 1'b1);
        repeat (5) tick();
        check_flag("read_resp_error_o", read_resp_error_o, 1'b1);  // sticky
    endtask

    task automatic hold_test();
        logic [INST_ADDR_W-1:0] pc_hold;
        tick();
        hold_ar = 1'b1;
        pc_hold = ar_addr;  // first address not yet issued
        repeat (10) begin
            tick();
            check_flag("pc_stall_o", pc_stall_o, 1'b1);
        end
        check_addr("ar_addr_o", ar_addr, pc_hold);
        foreach (got_addr[i]) begin
            if (got_addr[i] >= pc_hold) begin
                $display("word for address %h delivered while ARREADY was held low",
                         got_addr[i]);
                errors++;
            end
        end
        hold_ar = 1'b0;
        take_words(6);
    endtask

    initial begin
        rst_n         = 1'b0;
        stall_i       = 1'b1;  // keeps arvalid low around reset
        jump_i        = 1'b0;
        jump_target_i = '0;
        hold_ar       = 1'b0;
        err_en        = 1'b0;
        err_addr      = '0;
        next_addr     = RESET_PC;
        reset_and_fetch_test();
        stall_test();
        jump_test();
        error_test();
        hold_test();
        repeat (4) tick();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/ifu_pkg.sv
hw/ifu_pc_gen.sv
hw/ifu_addr_queue.sv
hw/ifu_inst_buffer.sv
hw/ifu_fetch_ctrl.sv
hw/ifu_top.sv
testbench/tb_axi_rom.sv
testbench/tb_ifu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_ifu_top -o sim_ifu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ifu > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation did not complete, see sim.log"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "testbench reported failure, see sim.log"
exit 1
